//--- Makefile
# Verilator build and run for the 16 KiB SRAM data store

VERILATOR ?= verilator
TOP       ?= sram_subsys_tb
LINT_TOP  ?= sram_subsys
FILELIST  ?= sram_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The log decides pass or fail, tee hides the simulator's own status
run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/fpga_ram.sv
// Generic single-port RAM model with registered read-first output
`timescale 1ns/1ps

module fpga_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  CLK,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  wen,
  output logic [DATA_WIDTH-1:0] dout
);

  // Storage array, one entry per address
  // Contents are not initialised
  logic [DATA_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];

  // Registered read port
  // Captures the old word at the presented address on every edge
  // A write in the same edge shows up only on the next access
  always_ff @(posedge CLK) begin
    dout <= mem[addr];
  end

  // Write port
  // Stores din when wen is high
  always_ff @(posedge CLK) begin
    if (wen) begin
      mem[addr] <= din;
    end
  end

endmodule

//--- rtl/spsram_1024x32.sv
// 1024x32 single-port SRAM macro built from four byte-lane RAMs with low-active controls
`timescale 1ns/1ps

module spsram_1024x32 (
  input  logic                          CLK,
  // Word address held internally while the macro is disabled
  input  logic [sram_pkg::BANK_ADDR_W-1:0] A,
  // Active-low chip enable
  input  logic                          CEN,
  input  logic [sram_pkg::DATA_W-1:0]      D,
  // Active-low global write enable
  input  logic                          GWEN,
  // Active-low per-bit write mask
  input  logic [sram_pkg::DATA_W-1:0]      WEN,
  output logic [sram_pkg::DATA_W-1:0]      Q
);

  import sram_pkg::*;

  // Last address seen with the chip enabled
  logic [BANK_ADDR_W-1:0] addr_hold;

  // Address actually presented to the lane RAMs
  logic [BANK_ADDR_W-1:0] ram_addr;

  // Capture the address on every enabled access
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      addr_hold <= A;
    end
  end

  // Live address while enabled and held address otherwise
  // Q keeps showing the last accessed word while CEN is high
  assign ram_addr = CEN ? addr_hold : A;

  // One RAM per byte lane
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    // Lane write strobe
    logic lane_wen;

    // Top mask bit of the lane governs the whole lane
    // Needs chip enabled and global write enabled too
    assign lane_wen = ~CEN & ~GWEN & ~WEN[l*LANE_W + LANE_W - 1];

    // Byte slice of D in and byte slice of Q out
    fpga_ram #(
      .DATA_WIDTH(LANE_W),
      .ADDR_WIDTH(BANK_ADDR_W)
    ) u_ram (
      .CLK  (CLK),
      .addr (ram_addr),
      .din  (D[l*LANE_W +: LANE_W]),
      .wen  (lane_wen),
      .dout (Q[l*LANE_W +: LANE_W])
    );
  end

endmodule

//--- rtl/sram_bank_array.sv
// Four-bank SRAM array with bank decode, byte-mask expansion and read steering
`timescale 1ns/1ps

module sram_bank_array (
  input  logic               CLK,
  input  logic               arst_n,
  input  sram_pkg::mem_req_t req,
  output sram_pkg::mem_rsp_t rsp
);

  import sram_pkg::*;

  // Bank index and in-bank offset from the word address
  logic [BANK_IDX_W-1:0]  bank_idx;
  logic [BANK_ADDR_W-1:0] bank_addr;

  // Per-bank chip enables, active low
  logic [NUM_BANKS-1:0]   bank_cen;

  // Shared write controls, active low
  logic                   gwen;
  logic [DATA_W-1:0]      wen_mask;

  // Read data of every bank
  logic [DATA_W-1:0]      bank_q [NUM_BANKS];

  // Accepted read this cycle
  logic                   rd_fire;

  // Read tracking for the response cycle
  logic                   rd_q;
  logic [BANK_IDX_W-1:0]  bank_sel_q;

  // Upper bits pick the bank, lower bits the word inside it
  assign bank_idx  = req.addr[ADDR_W-1 -: BANK_IDX_W];
  assign bank_addr = req.addr[BANK_ADDR_W-1:0];

  // Write only with a live request
  assign gwen    = ~(req.en & req.we);
  assign rd_fire = req.en & ~req.we;

  // Byte enables to inverted bit mask
  // Each enable spreads over the eight bits of its lane
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      wen_mask[l*LANE_W +: LANE_W] = {LANE_W{~req.be[l]}};
    end
  end

  // Bank decode
  // Only the addressed bank is enabled, and only when en is high
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_cen[b] = ~(req.en && (bank_idx == BANK_IDX_W'(b)));
    end
  end

  // The banks themselves
  // Address, data and mask are shared, CEN picks the target
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    spsram_1024x32 u_sram (
      .CLK  (CLK),
      .A    (bank_addr),
      .CEN  (bank_cen[b]),
      .D    (req.wdata),
      .GWEN (gwen),
      .WEN  (wen_mask),
      .Q    (bank_q[b])
    );
  end

  // Remember which bank a read went to
  // Q of that bank is valid one cycle later
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_q       <= 1'b0;
      bank_sel_q <= '0;
    end else begin
      rd_q <= rd_fire;
      if (rd_fire) begin
        bank_sel_q <= bank_idx;
      end
    end
  end

  // Response
  // Valid for exactly one cycle per read, data steered from the selected bank
  always_comb begin
    rsp.valid = rd_q;
    rsp.rdata = bank_q[bank_sel_q];
  end

endmodule

//--- rtl/sram_pkg.sv
// Shared widths and request/response types for the 16 KiB on-chip data store

package sram_pkg;

  // Word address of the whole store, 4096 words
  localparam int ADDR_W = 12;

  // Word address inside one 1024-word SRAM bank
  localparam int BANK_ADDR_W = 10;

  // Number of SRAM banks in the array
  localparam int NUM_BANKS = 4;

  // Bank index taken from the upper address bits
  localparam int BANK_IDX_W = ADDR_W - BANK_ADDR_W;

  // One byte lane
  localparam int LANE_W = 8;

  // Byte lanes per word
  localparam int NUM_LANES = 4;

  // Full word width
  localparam int DATA_W = LANE_W * NUM_LANES;

  // Request toward the store
  // One-cycle strobe, always accepted
  typedef struct packed {
    logic                 en;
    // Write when set, read when clear
    logic                 we;
    logic [ADDR_W-1:0]    addr;
    // Byte enables, active high, only meaningful on writes
    logic [NUM_LANES-1:0] be;
    logic [DATA_W-1:0]    wdata;
  } mem_req_t;

  // Response from the store
  // Valid pulses for one cycle per read
  typedef struct packed {
    logic              valid;
    // Defined only while valid is high
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

//--- rtl/sram_subsys.sv
// Top level of the 16 KiB data store, request/response structs around the bank array
`timescale 1ns/1ps

module sram_subsys (
  input  logic               CLK,
  input  logic               arst_n,
  // One-cycle request strobe, never stalled
  input  sram_pkg::mem_req_t req,
  // Read response, one cycle after the read request
  output sram_pkg::mem_rsp_t rsp
);

  // Banked storage
  // Decode, masking and read steering all live in the array
  sram_bank_array u_bank_array (
    .CLK    (CLK),
    .arst_n (arst_n),
    .req    (req),
    .rsp    (rsp)
  );

endmodule

//--- sram_subsys.f
rtl/sram_pkg.sv
rtl/fpga_ram.sv
rtl/spsram_1024x32.sv
rtl/sram_bank_array.sv
rtl/sram_subsys.sv
verif/sram_subsys_tb.sv

//--- verif/sram_subsys_tb.sv
// Table-driven testbench for the SRAM data store with a reference memory model
`timescale 1ns/1ps

module sram_subsys_tb;

  import sram_pkg::*;

  // Cycles to wait for outstanding read responses
  localparam int TIMEOUT_CYCLES = 16;
  // Random write/read pairs at the end of the table
  localparam int NUM_RANDOM = 24;

  // One table entry
  typedef struct {
    string                name;
    bit                   we;
    logic [ADDR_W-1:0]    addr;
    logic [NUM_LANES-1:0] be;
    logic [DATA_W-1:0]    wdata;
    // Take write data from $random instead of wdata
    bit                   rnd;
    // Idle cycles after the entry
    int                   idle;
  } op_t;

  // Outstanding read with its expected data and issue cycle
  typedef struct {
    string             name;
    logic [DATA_W-1:0] data;
    int                cyc;
  } rd_t;

  logic     CLK;
  logic     arst_n;
  mem_req_t req;
  mem_rsp_t rsp;

  op_t               ops[$];
  rd_t               pend[$];
  // Sparse reference memory indexed by word address
  logic [DATA_W-1:0] ref_mem [int];
  logic [ADDR_W-1:0] rnd_addr [NUM_RANDOM];

  int seed;
  int errors;
  int reads_checked;
  int cyc;

  sram_subsys dut0 (
    .CLK    (CLK),
    .arst_n (arst_n),
    .req    (req),
    .rsp    (rsp)
  );

  // 40 ns clock
  always #20 CLK = ~CLK;

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic add_op(input string name, input bit we, input logic [ADDR_W-1:0] addr,
                        input logic [NUM_LANES-1:0] be, input logic [DATA_W-1:0] wdata,
                        input bit rnd, input int idle);
    op_t op;
    op.name  = name;
    op.we    = we;
    op.addr  = addr;
    op.be    = be;
    op.wdata = wdata;
    op.rnd   = rnd;
    op.idle  = idle;
    ops.push_back(op);
  endtask

  // Lane-by-lane merge of a write into the reference
  task automatic update_ref(input logic [ADDR_W-1:0] addr, input logic [NUM_LANES-1:0] be,
                            input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] word;
    word = ref_mem.exists(int'(addr)) ? ref_mem[int'(addr)] : 'x;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (be[l]) begin
        word[l*LANE_W +: LANE_W] = data[l*LANE_W +: LANE_W];
      end
    end
    ref_mem[int'(addr)] = word;
  endtask

  task automatic build_table();
    int r;
    // Full word then a partial write over it so lanes 1 and 3 keep the old bytes
    add_op("full_wr", 1'b1, 12'h005, 4'hf, 32'hdead_beef, 1'b0, 1);
    add_op("full_rd", 1'b0, 12'h005, 4'h0, '0, 1'b0, 2);
    add_op("part_wr", 1'b1, 12'h005, 4'b0101, 32'h1122_3344, 1'b0, 1);
    add_op("part_rd", 1'b0, 12'h005, 4'h0, '0, 1'b0, 2);
    // Same offset in every bank
    add_op("bank0_wr", 1'b1, 12'h0a7, 4'hf, 32'hb000_00a7, 1'b0, 0);
    add_op("bank1_wr", 1'b1, 12'h4a7, 4'hf, 32'hb111_14a7, 1'b0, 0);
    add_op("bank2_wr", 1'b1, 12'h8a7, 4'hf, 32'hb222_28a7, 1'b0, 0);
    add_op("bank3_wr", 1'b1, 12'hca7, 4'hf, 32'hb333_3ca7, 1'b0, 1);
    add_op("bank0_rd", 1'b0, 12'h0a7, 4'h0, '0, 1'b0, 1);
    add_op("bank1_rd", 1'b0, 12'h4a7, 4'h0, '0, 1'b0, 1);
    add_op("bank2_rd", 1'b0, 12'h8a7, 4'h0, '0, 1'b0, 1);
    add_op("bank3_rd", 1'b0, 12'hca7, 4'h0, '0, 1'b0, 1);
    // Back-to-back reads hopping between banks
    add_op("b2b_rd0", 1'b0, 12'hca7, 4'h0, '0, 1'b0, 0);
    add_op("b2b_rd1", 1'b0, 12'h005, 4'h0, '0, 1'b0, 0);
    add_op("b2b_rd2", 1'b0, 12'h4a7, 4'h0, '0, 1'b0, 0);
    add_op("b2b_rd3", 1'b0, 12'h8a7, 4'h0, '0, 1'b0, 2);
    // Random addresses with data drawn when the write is driven
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      rnd_addr[i] = r[ADDR_W-1:0];
      add_op($sformatf("rnd_wr_%0d", i), 1'b1, rnd_addr[i], 4'hf, '0, 1'b1, 0);
    end
    // Mix of streamed and spaced reads
    for (int i = 0; i < NUM_RANDOM; i++) begin
      add_op($sformatf("rnd_rd_%0d", i), 1'b0, rnd_addr[i], 4'h0, '0, 1'b0,
             (i % 3 == 0) ? 1 : 0);
    end
  endtask

  // Advance one clock, check the response and go idle
  task automatic step_cycle();
    rd_t rd;
    @(posedge CLK);
    cyc++;
    #2;
    if (rsp.valid) begin
      if (pend.size() == 0) begin
        $display("ERROR: rsp.valid high at cycle %0d with no read outstanding", cyc);
        errors++;
      end else begin
        rd = pend.pop_front();
        check_value({rd.name, "_latency"}, 32'd1, 32'(cyc - rd.cyc));
        check_value(rd.name, rd.data, rsp.rdata);
        reads_checked++;
      end
    end
    req = '0;
  endtask

  // Present one entry for a single cycle
  task automatic drive_op(input op_t op);
    logic [DATA_W-1:0] data;
    rd_t               rd;
    data      = op.rnd ? DATA_W'($random(seed)) : op.wdata;
    req.en    = 1'b1;
    req.we    = op.we;
    req.addr  = op.addr;
    req.be    = op.we ? op.be : '0;
    req.wdata = op.we ? data : '0;
    if (op.we) begin
      update_ref(op.addr, op.be, data);
    end else begin
      if (!ref_mem.exists(int'(op.addr))) begin
        $display("ERROR: %s reads address %h that no entry has written", op.name, op.addr);
        errors++;
      end
      rd.name = op.name;
      rd.data = ref_mem.exists(int'(op.addr)) ? ref_mem[int'(op.addr)] : 'x;
      rd.cyc  = cyc;
      pend.push_back(rd);
    end
  endtask

  // Wait for all outstanding reads
  task automatic drain_reads();
    int waited;
    waited = 0;
    while (pend.size() != 0 && waited < TIMEOUT_CYCLES) begin
      step_cycle();
      waited++;
    end
    if (pend.size() != 0) begin
      $display("ERROR: timed out after %0d cycles with %0d read responses missing",
               waited, pend.size());
      errors++;
      pend.delete();
    end
  endtask

  initial begin
    CLK           = 1'b0;
    arst_n        = 1'b0;
    req           = '0;
    seed          = 32'hb7a4_2578;
    errors        = 0;
    reads_checked = 0;
    cyc           = 0;
    build_table();
    // Read strobes held through the 4 reset cycles must not raise valid
    req.en = 1'b1;
    repeat (4) begin
      @(posedge CLK);
      #2;
      check_value("reset_valid", '0, 32'(rsp.valid));
    end
    req    = '0;
    arst_n = 1'b1;
    foreach (ops[i]) begin
      step_cycle();
      drive_op(ops[i]);
      repeat (ops[i].idle) step_cycle();
      if (ops[i].idle > 0) begin
        drain_reads();
      end
    end
    drain_reads();
    // Trailing idle cycles catch stray valid pulses
    repeat (2) step_cycle();
    $display("Done: %0d reads checked, %0d errors", reads_checked, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
